//--- tb.f
verilog/ppu_pkg.sv
verilog/ppu_reg_decode.sv
verilog/ppu_vram_port.sv
verilog/ppu_frame_timing.sv
verilog/ppu_cpu_readback.sv
verilog/ppu_top.sv
bench/ppu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the PPU register block testbench with Verilator and run it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot change to the project directory"
	exit 1
fi

verilator --binary --timing --assert --top-module ppu_tb -f tb.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/Vppu_tb 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -qF "*** TEST PASSED ***" <<< "$sim_output"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- bench/ppu_tb.sv
`default_nettype none

module ppu_tb;

	// Small frame so vblank and NMI come around quickly
	localparam logic [9:0] CYCLES_PER_LINE = 10'd20;
	localparam logic [9:0] LINES_PER_FRAME = 10'd12;
	localparam logic [9:0] VBLANK_LINE     = 10'd8;
	localparam logic [9:0] PRERENDER_LINE  = 10'd11;
	localparam int FRAME_CYCLES = 20 * 12;

	localparam int RESET_CYCLES = 8;
	localparam int DRIVE_DELAY  = 1;
	localparam int NUM_WRITES   = 24;
	localparam int NUM_READS    = 16;
	// Data accesses plus register writes and status reads
	localparam int ACCESS_COUNT    = 2 * NUM_WRITES + 2 * NUM_READS + 32;
	localparam int WATCHDOG_CYCLES = 5 * FRAME_CYCLES + 8 * ACCESS_COUNT + RESET_CYCLES;
	localparam int NMI_WAIT_LIMIT  = 2 * FRAME_CYCLES;

	logic       CLK;
	logic       RESET;
	logic [2:0] CPU_ADDR;
	logic [7:0] CPU_DATA_IN;
	logic       CPU_WREN;
	logic       CPU_RDEN;
	wire  [7:0] CPU_DATA_OUT;
	wire        NMI_N;
	wire  [7:0] PPU_DATA_IN;
	wire [13:0] PPU_ADDR;
	wire  [7:0] PPU_DATA_OUT;
	wire        PPU_READ;
	wire        PPU_WRITE;

	// Video memory model of 16K bytes
	logic [7:0] vram [0:16383];

	logic [31:0] lfsr_state;
	string       test_name;
	// Expected read buffer and expected CPU readback byte
	logic [7:0]  exp_buf;
	logic [7:0]  exp_rdata;

	ppu_top #(
		.CYCLES_PER_LINE (CYCLES_PER_LINE),
		.LINES_PER_FRAME (LINES_PER_FRAME),
		.VBLANK_LINE     (VBLANK_LINE),
		.PRERENDER_LINE  (PRERENDER_LINE)
	) UUT (
		.CLK          (CLK),
		.RESET        (RESET),
		.CPU_ADDR     (CPU_ADDR),
		.CPU_DATA_IN  (CPU_DATA_IN),
		.CPU_WREN     (CPU_WREN),
		.CPU_RDEN     (CPU_RDEN),
		.CPU_DATA_OUT (CPU_DATA_OUT),
		.NMI_N        (NMI_N),
		.PPU_DATA_IN  (PPU_DATA_IN),
		.PPU_ADDR     (PPU_ADDR),
		.PPU_DATA_OUT (PPU_DATA_OUT),
		.PPU_READ     (PPU_READ),
		.PPU_WRITE    (PPU_WRITE)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	//======================================================================
	// Memory model
	//======================================================================

	// Mixes high address bits into the low byte
	function automatic logic [7:0] fill_byte(input logic [13:0] a);
		return a[7:0] ^ {a[13:8], 2'b01};
	endfunction

	// Asynchronous read and a write at the end of the pulse cycle
	assign PPU_DATA_IN = vram[PPU_ADDR];

	always @(posedge CLK) begin
		if (RESET) begin
			for (int i = 0; i < 16384; i++)
				vram[i] <= fill_byte(14'(i));
		end else if (PPU_WRITE) begin
			vram[PPU_ADDR] <= PPU_DATA_OUT;
		end
	end

	//======================================================================
	// Random numbers and failure reporting
	//======================================================================

	// Galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		return s >> 1;
	endfunction

	// One LFSR step per bit taken
	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic abort_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "Stopped at first failure");
	endtask

	task automatic expect_equal(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("[ERROR] %s (%s): expected 0x%0h, actual 0x%0h",
				test_name, what, expected, actual);
			abort_run();
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK);
		$display("Watchdog expired after %0d cycles, the test did not finish", WATCHDOG_CYCLES);
		abort_run();
	end

	//======================================================================
	// CPU bus accesses
	//======================================================================

	// Every task starts and ends just after a rising edge
	task automatic write_register(input logic [2:0] reg_num, input logic [7:0] data);
		CPU_ADDR    = reg_num;
		CPU_DATA_IN = data;
		CPU_WREN    = 1'b1;
		@(posedge CLK);
		#DRIVE_DELAY;
		CPU_WREN = 1'b0;
	endtask

	task automatic read_register(input logic [2:0] reg_num);
		CPU_ADDR = reg_num;
		CPU_RDEN = 1'b1;
		@(posedge CLK);
		#DRIVE_DELAY;
		CPU_RDEN = 1'b0;
	endtask

	// High byte first, with chosen values in the two unused bits
	task automatic load_address(input logic [13:0] addr, input logic [1:0] top);
		write_register(ppu_pkg::REG_ADDR, {top, addr[13:8]});
		write_register(ppu_pkg::REG_ADDR, addr[7:0]);
	endtask

	// Pulse comes in the cycle after the strobe, then one more idle cycle
	task automatic vram_write_access(input logic [7:0] data, input logic [13:0] exp_addr);
		write_register(ppu_pkg::REG_DATA, data);
		expect_equal("write pulse", 32'd1, 32'(PPU_WRITE));
		expect_equal("write address", 32'(exp_addr), 32'(PPU_ADDR));
		expect_equal("write data", 32'(data), 32'(PPU_DATA_OUT));
		@(posedge CLK);
		#DRIVE_DELAY;
		expect_equal("write pulse end", 32'd0, 32'(PPU_WRITE));
		@(posedge CLK);
		#DRIVE_DELAY;
	endtask

	// CPU gets the old buffer, memory refills it from the pulse address
	task automatic vram_read_access(input logic [13:0] exp_addr);
		read_register(ppu_pkg::REG_DATA);
		expect_equal("read data", 32'(exp_buf), 32'(CPU_DATA_OUT));
		expect_equal("read pulse", 32'd1, 32'(PPU_READ));
		expect_equal("read address", 32'(exp_addr), 32'(PPU_ADDR));
		exp_rdata = exp_buf;
		exp_buf   = vram[exp_addr];
		@(posedge CLK);
		#DRIVE_DELAY;
		expect_equal("read pulse end", 32'd0, 32'(PPU_READ));
		@(posedge CLK);
		#DRIVE_DELAY;
	endtask

	// Bit 7 is only compared when the vblank state is known
	task automatic status_access(input logic check_vb, input logic exp_vb);
		read_register(ppu_pkg::REG_STATUS);
		if (check_vb) begin
			expect_equal("status vblank", 32'(exp_vb), 32'(CPU_DATA_OUT[7]));
			exp_rdata[7] = exp_vb;
		end
		expect_equal("status low bits", 32'({2'b00, exp_rdata[4:0]}), 32'(CPU_DATA_OUT[6:0]));
		exp_rdata[6:5] = 2'b00;
	endtask

	// Counts cycles up to a high to low change of NMI_N
	task automatic wait_nmi_fall(output int cycles);
		logic prev_n;
		logic fell;
		prev_n = NMI_N;
		fell   = 1'b0;
		cycles = 0;
		while (!fell && cycles < NMI_WAIT_LIMIT) begin
			@(posedge CLK);
			#DRIVE_DELAY;
			cycles++;
			fell   = prev_n && !NMI_N;
			prev_n = NMI_N;
		end
		assert (fell) else begin
			$display("NMI_N did not fall within %0d cycles", NMI_WAIT_LIMIT);
			abort_run();
		end
	endtask

	//======================================================================
	// Test sequence
	//======================================================================

	initial begin
		logic [31:0] r;
		logic [13:0] addr;
		logic [13:0] write_start;
		logic [13:0] step;
		logic        down;
		int          nmi_cycles;

		RESET       = 1'b1;
		CPU_ADDR    = 3'd0;
		CPU_DATA_IN = 8'h00;
		CPU_WREN    = 1'b0;
		CPU_RDEN    = 1'b0;
		lfsr_state  = 32'h2f0a;
		exp_buf     = 8'h00;
		exp_rdata   = 8'h00;
		write_start = '0;
		test_name   = "reset";
		repeat (RESET_CYCLES) @(posedge CLK);
		#DRIVE_DELAY;
		RESET = 1'b0;

		// Idle outputs straight out of reset
		expect_equal("nmi", 32'd1, 32'(NMI_N));
		expect_equal("read pulse", 32'd0, 32'(PPU_READ));
		expect_equal("write pulse", 32'd0, 32'(PPU_WRITE));
		expect_equal("cpu data", 32'd0, 32'(CPU_DATA_OUT));

		// Increment 1 then 32 with random unused control bits
		test_name = "vram writes";
		for (int pass = 0; pass < 2; pass++) begin
			down = (pass == 1);
			step = down ? 14'd32 : 14'd1;
			random_bits(6, r);
			write_register(ppu_pkg::REG_CTRL, {1'b0, r[5:2], down, r[1:0]});
			random_bits(16, r);
			addr = r[13:0];
			if (!down)
				write_start = addr;
			load_address(addr, r[15:14]);
			for (int k = 0; k < NUM_WRITES; k++) begin
				random_bits(8, r);
				vram_write_access(r[7:0], addr);
				addr = addr + step;
			end
		end

		// Read back the increment-1 block, then a random column
		test_name = "vram reads";
		write_register(ppu_pkg::REG_CTRL, 8'h00);
		addr = write_start;
		load_address(addr, 2'b00);
		for (int k = 0; k < NUM_READS; k++) begin
			vram_read_access(addr);
			addr = addr + 14'd1;
		end
		write_register(ppu_pkg::REG_CTRL, 8'h04);
		random_bits(14, r);
		addr = r[13:0];
		load_address(addr, 2'b00);
		for (int k = 0; k < NUM_READS; k++) begin
			vram_read_access(addr);
			addr = addr + 14'd32;
		end

		// Lone first address write, then status clears the toggle
		test_name = "write toggle";
		random_bits(8, r);
		write_register(ppu_pkg::REG_ADDR, r[7:0]);
		status_access(1'b0, 1'b0);
		random_bits(16, r);
		addr = r[13:0];
		load_address(addr, r[15:14]);
		random_bits(8, r);
		vram_write_access(r[7:0], addr);

		// Scroll write takes the first slot of the shared pair
		random_bits(16, r);
		write_register(ppu_pkg::REG_SCROLL, r[7:0]);
		write_register(ppu_pkg::REG_ADDR, r[15:8]);
		random_bits(16, r);
		addr = r[13:0];
		load_address(addr, r[15:14]);
		random_bits(8, r);
		vram_write_access(r[7:0], addr);

		// First fall may follow an enable inside vblank, so time the next one
		test_name = "nmi timing";
		write_register(ppu_pkg::REG_CTRL, 8'h80);
		wait_nmi_fall(nmi_cycles);
		wait_nmi_fall(nmi_cycles);
		expect_equal("nmi fall spacing", 32'(FRAME_CYCLES), 32'(nmi_cycles));

		// Just after the vblank edge
		test_name = "status in vblank";
		status_access(1'b1, 1'b1);
		expect_equal("nmi released", 32'd1, 32'(NMI_N));
		status_access(1'b1, 1'b0);
		expect_equal("nmi stays high", 32'd1, 32'(NMI_N));

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/ppu_top.sv
`default_nettype none

module ppu_top #(
	parameter logic [9:0] CYCLES_PER_LINE = ppu_pkg::DEF_CYCLES_PER_LINE,
	parameter logic [9:0] LINES_PER_FRAME = ppu_pkg::DEF_LINES_PER_FRAME,
	parameter logic [9:0] VBLANK_LINE     = ppu_pkg::DEF_VBLANK_LINE,
	parameter logic [9:0] PRERENDER_LINE  = ppu_pkg::DEF_PRERENDER_LINE
) (
	input  wire                              CLK,
	input  wire                              RESET,
	// CPU bus
	input  wire [2:0]                        CPU_ADDR,
	input  wire [7:0]                        CPU_DATA_IN,
	input  wire                              CPU_WREN,
	input  wire                              CPU_RDEN,
	output logic [7:0]                       CPU_DATA_OUT,
	output logic                             NMI_N,
	// Video memory bus
	input  wire [7:0]                        PPU_DATA_IN,
	output logic [ppu_pkg::VRAM_ADDR_W-1:0]  PPU_ADDR,
	output logic [7:0]                       PPU_DATA_OUT,
	output logic                             PPU_READ,
	output logic                             PPU_WRITE
);

	logic                            data_write;
	logic                            data_read;
	logic                            status_read;
	logic                            increment_down;
	logic                            nmi_enable;
	logic                            addr_load;
	logic [ppu_pkg::VRAM_ADDR_W-1:0] addr_load_value;
	logic [7:0]                      read_buffer;
	logic                            vblank;

	// Register decode and control state
	ppu_reg_decode u_reg_decode (
		.CLK             (CLK),
		.RESET           (RESET),
		.cpu_addr        (CPU_ADDR),
		.cpu_wdata       (CPU_DATA_IN),
		.cpu_wren        (CPU_WREN),
		.cpu_rden        (CPU_RDEN),
		.data_write      (data_write),
		.data_read       (data_read),
		.status_read     (status_read),
		.increment_down  (increment_down),
		.nmi_enable      (nmi_enable),
		.addr_load       (addr_load),
		.addr_load_value (addr_load_value)
	);

	// PPUDATA accesses on the video memory bus
	ppu_vram_port u_vram_port (
		.CLK             (CLK),
		.RESET           (RESET),
		.data_write      (data_write),
		.data_read       (data_read),
		.cpu_wdata       (CPU_DATA_IN),
		.increment_down  (increment_down),
		.addr_load       (addr_load),
		.addr_load_value (addr_load_value),
		.ppu_data_in     (PPU_DATA_IN),
		.ppu_addr        (PPU_ADDR),
		.ppu_data_out    (PPU_DATA_OUT),
		.ppu_read        (PPU_READ),
		.ppu_write       (PPU_WRITE),
		.read_buffer     (read_buffer)
	);

	// Frame position, vblank and NMI
	ppu_frame_timing #(
		.CYCLES_PER_LINE (CYCLES_PER_LINE),
		.LINES_PER_FRAME (LINES_PER_FRAME),
		.VBLANK_LINE     (VBLANK_LINE),
		.PRERENDER_LINE  (PRERENDER_LINE)
	) u_frame_timing (
		.CLK         (CLK),
		.RESET       (RESET),
		.status_read (status_read),
		.nmi_enable  (nmi_enable),
		.vblank      (vblank),
		.nmi_n       (NMI_N)
	);

	// Byte returned on CPU reads
	ppu_cpu_readback u_cpu_readback (
		.CLK          (CLK),
		.RESET        (RESET),
		.data_read    (data_read),
		.status_read  (status_read),
		.vblank       (vblank),
		.read_buffer  (read_buffer),
		.cpu_data_out (CPU_DATA_OUT)
	);

endmodule

`default_nettype wire

//--- verilog/ppu_cpu_readback.sv
`default_nettype none

module ppu_cpu_readback (
	input  wire        CLK,
	input  wire        RESET,
	input  wire        data_read,
	input  wire        status_read,
	input  wire        vblank,
	input  wire [7:0]  read_buffer,
	output logic [7:0] cpu_data_out
);

	// Byte seen by the CPU, held between reads
	always_ff @(posedge CLK) begin
		if (RESET) begin
			cpu_data_out <= 8'h00;
		end else if (status_read) begin
			// Sprite bits read as zero, low bits keep the last value
			cpu_data_out <= {vblank, 2'b00, cpu_data_out[4:0]};
		end else if (data_read) begin
			// Buffered read returns the byte from the previous access
			cpu_data_out <= read_buffer;
		end
	end

endmodule

`default_nettype wire

//--- verilog/ppu_frame_timing.sv
`default_nettype none

module ppu_frame_timing #(
	parameter logic [9:0] CYCLES_PER_LINE = ppu_pkg::DEF_CYCLES_PER_LINE,
	parameter logic [9:0] LINES_PER_FRAME = ppu_pkg::DEF_LINES_PER_FRAME,
	parameter logic [9:0] VBLANK_LINE     = ppu_pkg::DEF_VBLANK_LINE,
	parameter logic [9:0] PRERENDER_LINE  = ppu_pkg::DEF_PRERENDER_LINE
) (
	input  wire  CLK,
	input  wire  RESET,
	input  wire  status_read,
	input  wire  nmi_enable,
	output logic vblank,
	output logic nmi_n
);

	// Position within the frame
	logic [9:0] cycle_cnt;
	logic [9:0] line_cnt;

	logic line_end;
	logic frame_end;
	logic vblank_start;
	logic vblank_end;

	assign line_end  = (cycle_cnt == CYCLES_PER_LINE - 10'd1);
	assign frame_end = (line_end && line_cnt == LINES_PER_FRAME - 10'd1);

	// Flag changes on the edge that leaves cycle 1 of the line
	assign vblank_start = (line_cnt == VBLANK_LINE) && (cycle_cnt == 10'd1);
	assign vblank_end   = (line_cnt == PRERENDER_LINE) && (cycle_cnt == 10'd1);

	//======================================================================
	// Cycle and scanline counters
	//======================================================================

	always_ff @(posedge CLK) begin
		if (RESET) begin
			cycle_cnt <= 10'd0;
			line_cnt  <= 10'd0;
		end else begin
			if (line_end)
				cycle_cnt <= 10'd0;
			else
				cycle_cnt <= cycle_cnt + 10'd1;

			if (frame_end)
				line_cnt <= 10'd0;
			else if (line_end)
				line_cnt <= line_cnt + 10'd1;
		end
	end

	//======================================================================
	// Vblank flag and NMI
	//======================================================================

	always_ff @(posedge CLK) begin
		if (RESET)
			vblank <= 1'b0;
		else if (vblank_start)
			vblank <= 1'b1;
		else if (vblank_end || status_read)
			vblank <= 1'b0;
	end

	// Active low, also drops when NMI gets enabled inside vblank
	assign nmi_n = ~(vblank & nmi_enable);

endmodule

`default_nettype wire

//--- verilog/ppu_vram_port.sv
`default_nettype none

module ppu_vram_port (
	input  wire                              CLK,
	input  wire                              RESET,
	input  wire                              data_write,
	input  wire                              data_read,
	input  wire [7:0]                        cpu_wdata,
	input  wire                              increment_down,
	input  wire                              addr_load,
	input  wire [ppu_pkg::VRAM_ADDR_W-1:0]   addr_load_value,
	input  wire [7:0]                        ppu_data_in,
	output logic [ppu_pkg::VRAM_ADDR_W-1:0]  ppu_addr,
	output logic [7:0]                       ppu_data_out,
	output logic                             ppu_read,
	output logic                             ppu_write,
	output logic [7:0]                       read_buffer
);

	// Current video address, shown on the memory bus at all times
	logic [ppu_pkg::VRAM_ADDR_W-1:0] vram_addr;
	logic [ppu_pkg::VRAM_ADDR_W-1:0] addr_step;

	// 1 going across, 32 going down
	assign addr_step = increment_down ? ppu_pkg::INC_DOWN : ppu_pkg::INC_ACROSS;
	assign ppu_addr  = vram_addr;

	//======================================================================
	// Bus pulses
	//======================================================================

	// Each access runs one cycle after its CPU strobe
	always_ff @(posedge CLK) begin
		if (RESET) begin
			ppu_write <= 1'b0;
			ppu_read  <= 1'b0;
		end else begin
			ppu_write <= data_write;
			ppu_read  <= data_read;
		end
	end

	// Write byte held for the pulse cycle
	always_ff @(posedge CLK) begin
		if (data_write)
			ppu_data_out <= cpu_wdata;
	end

	//======================================================================
	// Address and read buffer
	//======================================================================

	always_ff @(posedge CLK) begin
		if (RESET) begin
			vram_addr   <= '0;
			read_buffer <= 8'h00;
		end else begin
			// Load from PPUADDR wins, the spacing rule keeps it off an access
			if (addr_load)
				vram_addr <= addr_load_value;
			else if (ppu_write || ppu_read)
				vram_addr <= vram_addr + addr_step;

			// Memory answers in the same cycle, so capture at the pulse end
			if (ppu_read)
				read_buffer <= ppu_data_in;
		end
	end

endmodule

`default_nettype wire

//--- verilog/ppu_reg_decode.sv
`default_nettype none

module ppu_reg_decode (
	input  wire                          CLK,
	input  wire                          RESET,
	input  wire [2:0]                    cpu_addr,
	input  wire ppu_pkg::cpu_wdata_u     cpu_wdata,
	input  wire                          cpu_wren,
	input  wire                          cpu_rden,
	output logic                         data_write,
	output logic                         data_read,
	output logic                         status_read,
	output logic                         increment_down,
	output logic                         nmi_enable,
	output logic                         addr_load,
	output logic [ppu_pkg::VRAM_ADDR_W-1:0] addr_load_value
);

	// Write strobes for the registers that carry state here
	logic ctrl_wr;
	logic scroll_wr;
	logic addr_wr;

	// Shared first/second write toggle for PPUSCROLL and PPUADDR
	logic write_toggle;

	// High address byte held between the two PPUADDR writes
	logic [5:0] addr_hi_q;

	//======================================================================
	// Strobe decode
	//======================================================================

	// rden and wren never overlap, so each case only sees one of them
	always_comb begin
		ctrl_wr     = 1'b0;
		scroll_wr   = 1'b0;
		addr_wr     = 1'b0;
		data_write  = 1'b0;
		data_read   = 1'b0;
		status_read = 1'b0;
		if (cpu_wren) begin
			case (cpu_addr)
				ppu_pkg::REG_CTRL:   ctrl_wr    = 1'b1;
				ppu_pkg::REG_SCROLL: scroll_wr  = 1'b1;
				ppu_pkg::REG_ADDR:   addr_wr    = 1'b1;
				ppu_pkg::REG_DATA:   data_write = 1'b1;
				// Mask and OAM writes land nowhere
				ppu_pkg::REG_MASK, ppu_pkg::REG_OAM_ADDR, ppu_pkg::REG_OAM_DATA: ;
				default: ;
			endcase
		end else if (cpu_rden) begin
			case (cpu_addr)
				ppu_pkg::REG_STATUS: status_read = 1'b1;
				ppu_pkg::REG_DATA:   data_read   = 1'b1;
				default: ;
			endcase
		end
	end

	// Second PPUADDR write loads the full address in the strobe cycle
	assign addr_load       = addr_wr & write_toggle;
	assign addr_load_value = {addr_hi_q, cpu_wdata};

	//======================================================================
	// Control bits, toggle and high address byte
	//======================================================================

	always_ff @(posedge CLK) begin
		if (RESET) begin
			nmi_enable     <= 1'b0;
			increment_down <= 1'b0;
			write_toggle   <= 1'b0;
			addr_hi_q      <= '0;
		end else begin
			if (ctrl_wr) begin
				nmi_enable     <= cpu_wdata.ctrl.nmi_enable;
				increment_down <= cpu_wdata.ctrl.increment_down;
			end

			// Scroll values are dropped, only the toggle side effect stays
			if (scroll_wr || addr_wr)
				write_toggle <= ~write_toggle;
			else if (status_read)
				write_toggle <= 1'b0;

			// First write of the pair, upper six bits
			if (addr_wr && !write_toggle)
				addr_hi_q <= cpu_wdata.addr.addr_hi;
		end
	end

endmodule

`default_nettype wire

//--- verilog/ppu_pkg.sv
`default_nettype none

package ppu_pkg;

	//======================================================================
	// Widths and register map
	//======================================================================

	// Video memory address is 14 bits, $0000-$3FFF
	localparam int VRAM_ADDR_W = 14;

	// CPU register numbers, mirrored every 8 bytes on the CPU bus
	localparam logic [2:0] REG_CTRL     = 3'd0;
	localparam logic [2:0] REG_MASK     = 3'd1;
	localparam logic [2:0] REG_STATUS   = 3'd2;
	localparam logic [2:0] REG_OAM_ADDR = 3'd3;
	localparam logic [2:0] REG_OAM_DATA = 3'd4;
	localparam logic [2:0] REG_SCROLL   = 3'd5;
	localparam logic [2:0] REG_ADDR     = 3'd6;
	localparam logic [2:0] REG_DATA     = 3'd7;

	// Address step after a PPUDATA access, across a row or down a column
	localparam logic [VRAM_ADDR_W-1:0] INC_ACROSS = 14'd1;
	localparam logic [VRAM_ADDR_W-1:0] INC_DOWN   = 14'd32;

	//======================================================================
	// Default NTSC frame timing
	//======================================================================

	localparam logic [9:0] DEF_CYCLES_PER_LINE = 10'd341;
	localparam logic [9:0] DEF_LINES_PER_FRAME = 10'd262;
	localparam logic [9:0] DEF_VBLANK_LINE     = 10'd241;
	localparam logic [9:0] DEF_PRERENDER_LINE  = 10'd261;

	//======================================================================
	// CPU write byte
	//======================================================================

	// PPUCTRL layout, nametable and pattern table bits are not kept
	typedef struct packed {
		logic       nmi_enable;
		logic [3:0] unused_hi;
		logic       increment_down;
		logic [1:0] unused_lo;
	} ctrl_view_t;

	// First PPUADDR write, top two bits fall outside the 14-bit space
	typedef struct packed {
		logic [1:0] unused;
		logic [5:0] addr_hi;
	} addr_hi_view_t;

	typedef union packed {
		ctrl_view_t    ctrl;
		addr_hi_view_t addr;
	} cpu_wdata_u;

endpackage

`default_nettype wire
